// File: if_pkg.sv
package if_pkg;

  // bus and fetch widths
  localparam int ADDR_W     = 32;
  localparam int BUS_W      = 64;  // one axi beat
  localparam int INST_W     = 32;
  localparam int CNT_W      = 32;  // hit/miss counters, also csr data width

  // cache geometry: 16 lines of 16 bytes
  localparam int LINE_BEATS = 2;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // addi x0,x0,0 shown to decode when nothing is valid
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // icache controller
  typedef enum logic [2:0] {
    IDLE,         // lookup on the incoming pc
    LOOKUP,       // replay after refill
    REFILL_REQ,   // present beat address
    REFILL_WAIT,  // wait for the beat to return
    FLUSH         // valid sweep, one line per cycle
  } cache_state_e;

  // control block register offsets
  typedef enum logic [3:0] {
    CTRL     = 4'h0,  // bit0 enable, bit1 flush (w1)
    HIT_CNT  = 4'h4,
    MISS_CNT = 4'h8
  } csr_reg_e;

endpackage

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall_i,
  input  logic                      redirect_valid_i,
  input  logic [if_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                      fetch_ack_i,
  output logic [if_pkg::ADDR_W-1:0] fetch_pc_o,
  output logic                      fetch_req_o
);
  import if_pkg::*;

  logic [ADDR_W-1:0] pc_q;  // next pc to hand to the cache

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_valid_i) begin
      pc_q <= redirect_pc_i;  // redirect beats stall and ack
    end else if (fetch_ack_i) begin
      pc_q <= pc_q + ADDR_W'(4);
    end
  end

  assign fetch_pc_o = pc_q;

  // no request while decode is stalled, and none in the redirect cycle
  // so the cache never accepts the stale pc
  assign fetch_req_o = !stall_i && !redirect_valid_i;

  // redirect targets come from execute, keep them word aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch_pc_o[1:0] == 2'b00
  );

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_req_i,
  input  logic [if_pkg::ADDR_W-1:0] fetch_pc_i,
  input  logic                      redirect_valid_i,
  input  logic                      stall_i,
  output logic                      fetch_ack_o,
  output logic                      inst_valid_o,
  output logic [if_pkg::INST_W-1:0] inst_o,
  output logic [if_pkg::ADDR_W-1:0] inst_pc_o,
  input  logic                      cache_en_i,
  input  logic                      flush_i,
  output logic                      hit_o,
  output logic                      miss_o,
  output logic                      mem_req_o,
  output logic [if_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                      mem_done_i,
  input  logic [if_pkg::BUS_W-1:0]  mem_rdata_i
);
  import if_pkg::*;

  cache_state_e          state_q;
  logic [TAG_W-1:0]      tag_q  [2**INDEX_W];
  logic [BUS_W-1:0]      data_q [2**INDEX_W][LINE_BEATS];
  logic [2**INDEX_W-1:0] valid_q;
  logic [ADDR_W-1:0]     req_pc_q;     // accepted pc
  logic                  uncached_q;   // fetch taken with cache off
  logic                  drop_q;       // redirect hit the fetch in flight
  logic [OFFSET_W-4:0]   beat_q;
  logic [INDEX_W-1:0]    flush_idx_q;
  logic                  flush_pend_q;
  logic                  out_valid_q;
  logic [INST_W-1:0]     out_inst_q;
  logic [ADDR_W-1:0]     out_pc_q;

  logic [ADDR_W-1:0]  sel_pc;
  logic [INDEX_W-1:0] sel_idx;
  logic [INDEX_W-1:0] req_idx;
  logic [BUS_W-1:0]   sel_beat;
  logic               lookup_hit;
  logic               flush_go;
  logic               deliver;
  logic [INST_W-1:0]  deliver_inst;

  // idle looks up the incoming pc, replay uses the held one
  assign sel_pc     = (state_q == IDLE) ? fetch_pc_i : req_pc_q;
  assign sel_idx    = sel_pc[OFFSET_W +: INDEX_W];
  assign req_idx    = req_pc_q[OFFSET_W +: INDEX_W];
  assign sel_beat   = data_q[sel_idx][sel_pc[OFFSET_W-1:3]];
  assign lookup_hit = valid_q[sel_idx] && (tag_q[sel_idx] == sel_pc[ADDR_W-1 -: TAG_W]);

  assign flush_go    = flush_i || flush_pend_q;
  assign fetch_ack_o = (state_q == IDLE) && fetch_req_i && !flush_go;
  assign hit_o       = fetch_ack_o && cache_en_i && lookup_hit;
  assign miss_o      = fetch_ack_o && !(cache_en_i && lookup_hit);  // cache off counts as miss

  assign mem_req_o  = (state_q == REFILL_REQ) || (state_q == REFILL_WAIT);
  assign mem_addr_o = uncached_q ? {req_pc_q[ADDR_W-1:3], 3'b000}
                                 : {req_pc_q[ADDR_W-1:OFFSET_W], beat_q, 3'b000};

  always_comb begin
    deliver      = 1'b0;
    deliver_inst = sel_pc[2] ? sel_beat[BUS_W-1 -: INST_W] : sel_beat[INST_W-1:0];
    case (state_q)
      IDLE:   deliver = hit_o;  // hit lands one cycle after accept
      LOOKUP: deliver = !drop_q && !redirect_valid_i;
      REFILL_WAIT: begin
        if (uncached_q && mem_done_i) begin  // bypass straight from the bus
          deliver      = !drop_q && !redirect_valid_i;
          deliver_inst = req_pc_q[2] ? mem_rdata_i[BUS_W-1 -: INST_W] : mem_rdata_i[INST_W-1:0];
        end
      end
      default: deliver = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      valid_q      <= '0;
      uncached_q   <= 1'b0;
      drop_q       <= 1'b0;
      beat_q       <= '0;
      flush_idx_q  <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      if (flush_i) flush_pend_q <= 1'b1;  // wait for idle
      if (redirect_valid_i && state_q != IDLE) drop_q <= 1'b1;
      case (state_q)
        IDLE: begin
          if (flush_go) begin
            flush_pend_q <= 1'b0;
            flush_idx_q  <= '0;
            state_q      <= FLUSH;
          end else if (fetch_ack_o) begin
            uncached_q <= !cache_en_i;
            drop_q     <= 1'b0;
            beat_q     <= '0;
            if (miss_o) state_q <= REFILL_REQ;
          end
        end
        REFILL_REQ: state_q <= REFILL_WAIT;
        REFILL_WAIT: begin
          if (mem_done_i) begin
            if (uncached_q) begin
              state_q <= IDLE;
            end else if (&beat_q) begin  // last beat, line complete
              valid_q[req_idx] <= 1'b1;
              state_q          <= LOOKUP;
            end else begin
              beat_q  <= beat_q + 1'b1;
              state_q <= REFILL_REQ;
            end
          end
        end
        LOOKUP: state_q <= IDLE;
        FLUSH: begin
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (&flush_idx_q) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // arrays and payload
  always_ff @(posedge clk) begin
    if (fetch_ack_o) req_pc_q <= fetch_pc_i;
    if (state_q == REFILL_WAIT && mem_done_i && !uncached_q) begin
      data_q[req_idx][beat_q] <= mem_rdata_i;
      tag_q[req_idx]          <= req_pc_q[ADDR_W-1 -: TAG_W];
    end
    if (deliver) begin
      out_inst_q <= deliver_inst;
      out_pc_q   <= sel_pc;
    end
  end

  // output register, held under stall, killed by redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (redirect_valid_i) begin
      out_valid_q <= 1'b0;
    end else if (deliver) begin
      out_valid_q <= 1'b1;
    end else if (!stall_i) begin
      out_valid_q <= 1'b0;  // consumed by decode
    end
  end

  assign inst_valid_o = out_valid_q;
  assign inst_o       = out_valid_q ? out_inst_q : NOP_INST;
  assign inst_pc_o    = out_pc_q;

  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    inst_valid_o && stall_i && !redirect_valid_i |=> $stable(inst_o) && $stable(inst_pc_o)
  );

  // a beat only comes back while the controller waits for it
  a_done_in_wait: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_done_i |-> state_q == REFILL_WAIT
  );

endmodule

// File: axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_i,
  input  logic [if_pkg::ADDR_W-1:0] addr_i,
  output logic                      done_o,
  output logic [if_pkg::BUS_W-1:0]  rdata_o,
  output logic                      m_axi_arvalid_o,
  input  logic                      m_axi_arready_i,
  output logic [if_pkg::ADDR_W-1:0] m_axi_araddr_o,
  input  logic                      m_axi_rvalid_i,
  output logic                      m_axi_rready_o,
  input  logic [if_pkg::BUS_W-1:0]  m_axi_rdata_i,
  input  logic [1:0]                m_axi_rresp_i
);
  import if_pkg::*;

  logic              arvalid_q;
  logic              rready_q;   // read outstanding
  logic              done_q;
  logic [ADDR_W-1:0] araddr_q;
  logic [BUS_W-1:0]  rdata_q;
  logic              start;

  // new read only when fully idle, skip the done cycle
  // since the requester still holds the old address there
  assign start = req_i && !arvalid_q && !rready_q && !done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (arvalid_q && m_axi_arready_i) begin
        arvalid_q <= 1'b0;  // ar taken, wait for r
        rready_q  <= 1'b1;
      end else if (start) begin
        arvalid_q <= 1'b1;
      end
      if (rready_q && m_axi_rvalid_i) begin
        rready_q <= 1'b0;
        done_q   <= 1'b1;  // one cycle pulse
      end
    end
  end

  // payload, response code not checked
  always_ff @(posedge clk) begin
    if (start) araddr_q <= addr_i;
    if (rready_q && m_axi_rvalid_i) rdata_q <= m_axi_rdata_i;
  end

  assign m_axi_arvalid_o = arvalid_q;
  assign m_axi_araddr_o  = araddr_q;
  assign m_axi_rready_o  = rready_q;
  assign done_o          = done_q;
  assign rdata_o         = rdata_q;

  a_ar_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o)
  );

  // r only taken while the requester still waits on the beat
  a_rready_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_axi_rready_o |-> req_i
  );

endmodule

// File: fetch_csr.sv
`timescale 1ns/1ps

module fetch_csr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         s_axi_awvalid_i,
  output logic                         s_axi_awready_o,
  input  logic [if_pkg::ADDR_W-1:0]    s_axi_awaddr_i,
  input  logic                         s_axi_wvalid_i,
  output logic                         s_axi_wready_o,
  input  logic [if_pkg::CNT_W-1:0]     s_axi_wdata_i,
  input  logic [if_pkg::CNT_W/8-1:0]   s_axi_wstrb_i,
  output logic                         s_axi_bvalid_o,
  input  logic                         s_axi_bready_i,
  output logic [1:0]                   s_axi_bresp_o,
  input  logic                         s_axi_arvalid_i,
  output logic                         s_axi_arready_o,
  input  logic [if_pkg::ADDR_W-1:0]    s_axi_araddr_i,
  output logic                         s_axi_rvalid_o,
  input  logic                         s_axi_rready_i,
  output logic [if_pkg::CNT_W-1:0]     s_axi_rdata_o,
  output logic [1:0]                   s_axi_rresp_o,
  input  logic                         hit_i,
  input  logic                         miss_i,
  output logic                         cache_en_o,
  output logic                         flush_o
);
  import if_pkg::*;

  logic             ctrl_wr;
  logic             flush_wr;
  logic             rd_fire;
  logic             en_q;
  logic             flush_q;
  logic             bvalid_q;
  logic             rvalid_q;
  logic [CNT_W-1:0] hit_cnt_q;
  logic [CNT_W-1:0] miss_cnt_q;
  logic [CNT_W-1:0] rdata_q;
  logic [CNT_W-1:0] rd_val;

  // aw and w taken together, only when b is free
  assign s_axi_awready_o = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q;
  assign s_axi_wready_o  = s_axi_awready_o;
  assign ctrl_wr  = s_axi_awready_o && (s_axi_awaddr_i == ADDR_W'(CTRL)) && s_axi_wstrb_i[0];
  assign flush_wr = ctrl_wr && s_axi_wdata_i[1];  // write one to flush

  assign s_axi_arready_o = !rvalid_q;
  assign rd_fire         = s_axi_arvalid_i && !rvalid_q;

  always_comb begin
    case (s_axi_araddr_i)
      ADDR_W'(CTRL):     rd_val = {{(CNT_W-1){1'b0}}, en_q};  // flush bit reads 0
      ADDR_W'(HIT_CNT):  rd_val = hit_cnt_q;
      ADDR_W'(MISS_CNT): rd_val = miss_cnt_q;
      default:           rd_val = '0;  // unmapped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q       <= 1'b1;  // cache on out of reset
      flush_q    <= 1'b0;
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end else begin
      flush_q <= flush_wr;
      if (ctrl_wr) en_q <= s_axi_wdata_i[0];
      // b one cycle after the write, r one cycle after ar
      if (s_axi_awready_o) bvalid_q <= 1'b1;
      else if (s_axi_bready_i) bvalid_q <= 1'b0;
      if (rd_fire) rvalid_q <= 1'b1;
      else if (s_axi_rready_i) rvalid_q <= 1'b0;
      if (flush_wr) begin
        hit_cnt_q  <= '0;
        miss_cnt_q <= '0;
      end else begin
        if (hit_i && !(&hit_cnt_q)) hit_cnt_q <= hit_cnt_q + 1'b1;     // saturate
        if (miss_i && !(&miss_cnt_q)) miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= rd_val;
  end

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = 2'b00;  // okay
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rdata_o  = rdata_q;
  assign s_axi_rresp_o  = 2'b00;
  assign cache_en_o     = en_q;
  assign flush_o        = flush_q;

endmodule

// File: if_stage.sv
`timescale 1ns/1ps

module if_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stall_i,
  input  logic                       redirect_valid_i,
  input  logic [if_pkg::ADDR_W-1:0]  redirect_pc_i,
  output logic                       inst_valid_o,
  output logic [if_pkg::INST_W-1:0]  inst_o,
  output logic [if_pkg::ADDR_W-1:0]  inst_pc_o,
  // refill read port
  output logic                       m_axi_arvalid_o,
  input  logic                       m_axi_arready_i,
  output logic [if_pkg::ADDR_W-1:0]  m_axi_araddr_o,
  input  logic                       m_axi_rvalid_i,
  output logic                       m_axi_rready_o,
  input  logic [if_pkg::BUS_W-1:0]   m_axi_rdata_i,
  input  logic [1:0]                 m_axi_rresp_i,
  // control registers
  input  logic                       s_axi_awvalid_i,
  output logic                       s_axi_awready_o,
  input  logic [if_pkg::ADDR_W-1:0]  s_axi_awaddr_i,
  input  logic                       s_axi_wvalid_i,
  output logic                       s_axi_wready_o,
  input  logic [if_pkg::CNT_W-1:0]   s_axi_wdata_i,
  input  logic [if_pkg::CNT_W/8-1:0] s_axi_wstrb_i,
  output logic                       s_axi_bvalid_o,
  input  logic                       s_axi_bready_i,
  output logic [1:0]                 s_axi_bresp_o,
  input  logic                       s_axi_arvalid_i,
  output logic                       s_axi_arready_o,
  input  logic [if_pkg::ADDR_W-1:0]  s_axi_araddr_i,
  output logic                       s_axi_rvalid_o,
  input  logic                       s_axi_rready_i,
  output logic [if_pkg::CNT_W-1:0]   s_axi_rdata_o,
  output logic [1:0]                 s_axi_rresp_o
);
  import if_pkg::*;

  logic [ADDR_W-1:0] fetch_pc;
  logic              fetch_req;
  logic              fetch_ack;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_done;
  logic [BUS_W-1:0]  mem_rdata;
  logic              cache_en;
  logic              flush_pulse;
  logic              hit_pulse;
  logic              miss_pulse;

  pc_gen i_pc_gen (
    .clk, .rst_n, .stall_i, .redirect_valid_i, .redirect_pc_i,
    .fetch_ack_i (fetch_ack),
    .fetch_pc_o  (fetch_pc),
    .fetch_req_o (fetch_req)
  );

  icache i_icache (
    .clk, .rst_n, .redirect_valid_i, .stall_i, .inst_valid_o, .inst_o, .inst_pc_o,
    .fetch_req_i (fetch_req),
    .fetch_pc_i  (fetch_pc),
    .fetch_ack_o (fetch_ack),
    .cache_en_i  (cache_en),
    .flush_i     (flush_pulse),
    .hit_o       (hit_pulse),
    .miss_o      (miss_pulse),
    .mem_req_o   (mem_req),
    .mem_addr_o  (mem_addr),
    .mem_done_i  (mem_done),
    .mem_rdata_i (mem_rdata)
  );

  axi_rd_master i_axi_rd_master (
    .clk, .rst_n,
    .req_i   (mem_req),
    .addr_i  (mem_addr),
    .done_o  (mem_done),
    .rdata_o (mem_rdata),
    .m_axi_arvalid_o, .m_axi_arready_i, .m_axi_araddr_o,
    .m_axi_rvalid_i, .m_axi_rready_o, .m_axi_rdata_i, .m_axi_rresp_i
  );

  fetch_csr i_fetch_csr (
    .clk, .rst_n,
    .s_axi_awvalid_i, .s_axi_awready_o, .s_axi_awaddr_i,
    .s_axi_wvalid_i, .s_axi_wready_o, .s_axi_wdata_i, .s_axi_wstrb_i,
    .s_axi_bvalid_o, .s_axi_bready_i, .s_axi_bresp_o,
    .s_axi_arvalid_i, .s_axi_arready_o, .s_axi_araddr_i,
    .s_axi_rvalid_o, .s_axi_rready_i, .s_axi_rdata_o, .s_axi_rresp_o,
    .hit_i      (hit_pulse),
    .miss_i     (miss_pulse),
    .cache_en_o (cache_en),
    .flush_o    (flush_pulse)
  );

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  logic [if_pkg::ADDR_W-1:0] araddr_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [if_pkg::BUS_W-1:0]  rdata_o,
  output logic [1:0]                rresp_o
);
  import if_pkg::*;

  integer seed;
  int     ar_wait;   // cycles left before arready
  int     r_wait;    // cycles left before rvalid
  logic   busy;      // address taken, response owed
  logic   ar_fire;   // ar handshake set up for the next rising edge
  logic   r_fire;

  // beat at a: upper half (a+4)^pattern, lower half a^pattern
  function automatic logic [BUS_W-1:0] beat_at(input logic [ADDR_W-1:0] a);
    return {(a + 32'd4) ^ 32'h5A5A_5A5A, a ^ 32'h5A5A_5A5A};
  endfunction

  initial seed = 10;

  assign rresp_o = 2'b00;  // always okay

  // everything moves on the falling edge, the master samples on the rising one
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rdata_o   = '0;
      busy      = 1'b0;
      ar_fire   = 1'b0;
      r_fire    = 1'b0;
      ar_wait   = 0;
      r_wait    = 0;
    end else begin
      if (ar_fire) begin  // address went over on the last edge
        arready_o = 1'b0;
        busy      = 1'b1;
        r_wait    = $random(seed) & 3;
      end
      if (r_fire) begin
        rvalid_o = 1'b0;
        busy     = 1'b0;
      end
      if (arvalid_i && !arready_o && !busy) begin
        if (ar_wait == 0) begin
          arready_o = 1'b1;
          rdata_o   = beat_at(araddr_i);  // araddr held until ready
          ar_wait   = $random(seed) & 3;  // delay for the next read
        end else begin
          ar_wait--;
        end
      end
      if (busy && !rvalid_o) begin
        if (r_wait == 0) rvalid_o = 1'b1;
        else r_wait--;
      end
      ar_fire = arready_o && arvalid_i;
      r_fire  = rvalid_o && rready_i;
    end
  end

endmodule

// File: tb_if_stage.sv
`timescale 1ns/1ps

module tb_if_stage;
  import if_pkg::*;

  localparam int PHASE1_N = 1500;  // stalls and redirects at any time
  localparam int PHASE2_N = 1000;  // after flush, counters checked
  localparam int PHASE3_N = 500;   // cache disabled
  localparam int TIMEOUT_CYCLES = (PHASE1_N + PHASE2_N + PHASE3_N) * 40 + 1000;

  logic               clk;
  logic               rst_n;
  logic               stall_i;
  logic               redirect_valid_i;
  logic [ADDR_W-1:0]  redirect_pc_i;
  logic               inst_valid_o;
  logic [INST_W-1:0]  inst_o;
  logic [ADDR_W-1:0]  inst_pc_o;
  logic               m_axi_arvalid_o;
  logic               m_axi_arready_i;
  logic [ADDR_W-1:0]  m_axi_araddr_o;
  logic               m_axi_rvalid_i;
  logic               m_axi_rready_o;
  logic [BUS_W-1:0]   m_axi_rdata_i;
  logic [1:0]         m_axi_rresp_i;
  logic               s_axi_awvalid_i;
  logic               s_axi_awready_o;
  logic [ADDR_W-1:0]  s_axi_awaddr_i;
  logic               s_axi_wvalid_i;
  logic               s_axi_wready_o;
  logic [CNT_W-1:0]   s_axi_wdata_i;
  logic [CNT_W/8-1:0] s_axi_wstrb_i;
  logic               s_axi_bvalid_o;
  logic               s_axi_bready_i;
  logic [1:0]         s_axi_bresp_o;
  logic               s_axi_arvalid_i;
  logic               s_axi_arready_o;
  logic [ADDR_W-1:0]  s_axi_araddr_i;
  logic               s_axi_rvalid_o;
  logic               s_axi_rready_i;
  logic [CNT_W-1:0]   s_axi_rdata_o;
  logic [1:0]         s_axi_rresp_o;

  integer                seed;
  int                    cycle_cnt = 0;
  int                    inst_errs;
  int                    cnt_errs;
  int                    sig_errs;
  logic [ADDR_W-1:0]     exp_pc;      // pc decode should see next
  logic                  held;        // shown instruction kept under stall
  logic                  model_en;    // cache enable as the model sees it
  logic [TAG_W-1:0]      sh_tag [2**INDEX_W];
  logic [2**INDEX_W-1:0] sh_valid;
  int                    hit_exp;
  int                    miss_exp;
  logic [CNT_W-1:0]      rd_data;

  if_stage i_dut (.*);

  tb_axi_mem i_mem (
    .clk, .rst_n,
    .arvalid_i (m_axi_arvalid_o),
    .arready_o (m_axi_arready_i),
    .araddr_i  (m_axi_araddr_o),
    .rvalid_o  (m_axi_rvalid_i),
    .rready_i  (m_axi_rready_o),
    .rdata_o   (m_axi_rdata_i),
    .rresp_o   (m_axi_rresp_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, fetch stage stopped making progress", cycle_cnt);
      $display("errors: %0d instruction, %0d counter, %0d signal",
               inst_errs, cnt_errs, sig_errs);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // both halves of the beat rule reduce to pc ^ pattern
  function automatic logic [INST_W-1:0] expect_inst(input logic [ADDR_W-1:0] pc);
    return pc ^ 32'h5A5A_5A5A;
  endfunction

  task automatic check_inst(input logic [INST_W-1:0] got_inst, input logic [INST_W-1:0] want_inst,
                            input logic [ADDR_W-1:0] got_pc, input logic [ADDR_W-1:0] want_pc);
    if (got_pc !== want_pc || got_inst !== want_inst) begin
      inst_errs++;
      $display("[FAIL] %0t ns: fetched pc %h inst %h, expected pc %h inst %h",
               $time, got_pc, got_inst, want_pc, want_inst);
    end
  endtask

  task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] want,
                             input string what);
    if (got !== want) begin
      cnt_errs++;
      $display("[FAIL] %0t ns: %s reads %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
    if (got !== want) begin
      sig_errs++;
      $display("[FAIL] %0t ns: %s code %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      sig_errs++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // one accepted fetch against the shadow tags
  task automatic account(input logic [ADDR_W-1:0] pc);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    idx = pc[OFFSET_W +: INDEX_W];
    tag = pc[ADDR_W-1 -: TAG_W];
    if (model_en && sh_valid[idx] && sh_tag[idx] == tag) begin
      hit_exp++;
    end else begin
      miss_exp++;
      if (model_en) begin  // refill allocates the line
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = tag;
      end
    end
  endtask

  task automatic reset_model(input logic en);
    model_en = en;
    sh_valid = '0;  // flush sweep
    hit_exp  = 0;
    miss_exp = 0;   // counters cleared with the flush
  endtask

  // outputs are stable at the falling edge
  task automatic observe();
    if (held && !inst_valid_o) begin
      inst_errs++;
      $display("error at %0t ns: instruction at pc %h dropped while stalled", $time, exp_pc);
    end
    if (inst_valid_o) begin
      check_inst(inst_o, expect_inst(exp_pc), inst_pc_o, exp_pc);
      if (!held) account(exp_pc);  // first cycle shown
    end
  endtask

  task automatic drive(input logic s, input logic r, input logic [ADDR_W-1:0] target);
    stall_i          = s;
    redirect_valid_i = r;
    redirect_pc_i    = target;
    held = inst_valid_o && s && !r;
    if (r) exp_pc = target;  // redirect beats stall
    else if (inst_valid_o && !s) exp_pc = exp_pc + ADDR_W'(4);  // consumed
  endtask

  task automatic run_fetches(input int n, input logic any_time);
    int                taken;
    logic              s;
    logic              r;
    logic [ADDR_W-1:0] target;
    taken = 0;
    while (taken < n) begin
      @(negedge clk);
      observe();
      s = ($random(seed) & 3) == 0;                     // 25%
      r = (($random(seed) & 32'h7FFF_FFFF) % 20) == 0;  // 5%
      if (!any_time && !inst_valid_o) r = 1'b0;  // only when nothing is in flight
      target = RESET_PC + ADDR_W'(($random(seed) & 127) << 2);  // 512-byte window
      if (inst_valid_o && !s && !r) taken++;
      drive(s, r, target);
    end
    // last consumption already accepted the next pc, park on it
    do begin
      @(negedge clk);
      observe();
      drive(1'b1, 1'b0, exp_pc);
    end while (!inst_valid_o);
  endtask

  task automatic restart(input logic [ADDR_W-1:0] target);
    @(negedge clk);
    observe();
    drive(1'b0, 1'b1, target);
  endtask

  task automatic csr_write(input logic [ADDR_W-1:0] addr, input logic [CNT_W-1:0] data);
    @(negedge clk);
    s_axi_awvalid_i = 1'b1;
    s_axi_awaddr_i  = addr;
    s_axi_wvalid_i  = 1'b1;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = '1;
    s_axi_bready_i  = 1'b1;
    @(negedge clk);
    while (!s_axi_bvalid_o) @(negedge clk);
    check_resp(s_axi_bresp_o, 2'b00, "write response");
    // aw and w still offered, must not be taken twice
    check_flag(s_axi_awready_o, 1'b0, "s_axi_awready_o with b pending");
    check_flag(s_axi_wready_o, 1'b0, "s_axi_wready_o with b pending");
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    @(negedge clk);
    s_axi_bready_i = 1'b0;
  endtask

  task automatic csr_read(input logic [ADDR_W-1:0] addr, output logic [CNT_W-1:0] data);
    @(negedge clk);
    check_flag(s_axi_arready_o, 1'b1, "s_axi_arready_o when idle");
    s_axi_arvalid_i = 1'b1;
    s_axi_araddr_i  = addr;
    s_axi_rready_i  = 1'b1;
    @(negedge clk);
    while (!s_axi_rvalid_o) @(negedge clk);
    check_resp(s_axi_rresp_o, 2'b00, "read response");
    data            = s_axi_rdata_o;
    s_axi_arvalid_i = 1'b0;
    @(negedge clk);
    s_axi_rready_i = 1'b0;
  endtask

  task automatic check_counters();
    csr_read(ADDR_W'(HIT_CNT), rd_data);
    check_count(rd_data, CNT_W'(hit_exp), "HIT_CNT");
    csr_read(ADDR_W'(MISS_CNT), rd_data);
    check_count(rd_data, CNT_W'(miss_exp), "MISS_CNT");
  endtask

  initial begin
    seed             = 10;
    inst_errs        = 0;
    cnt_errs         = 0;
    sig_errs         = 0;
    held             = 1'b0;
    exp_pc           = RESET_PC;
    reset_model(1'b1);
    rst_n            = 1'b0;
    stall_i          = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    s_axi_awvalid_i  = 1'b0;
    s_axi_awaddr_i   = '0;
    s_axi_wvalid_i   = 1'b0;
    s_axi_wdata_i    = '0;
    s_axi_wstrb_i    = '0;
    s_axi_bready_i   = 1'b0;
    s_axi_arvalid_i  = 1'b0;
    s_axi_araddr_i   = '0;
    s_axi_rready_i   = 1'b0;
    repeat (2) @(negedge clk);
    // handshake outputs quiet out of reset
    check_flag(inst_valid_o, 1'b0, "inst_valid_o in reset");
    check_flag(m_axi_arvalid_o, 1'b0, "m_axi_arvalid_o in reset");
    check_flag(m_axi_rready_o, 1'b0, "m_axi_rready_o in reset");
    check_flag(s_axi_bvalid_o, 1'b0, "s_axi_bvalid_o in reset");
    check_flag(s_axi_rvalid_o, 1'b0, "s_axi_rvalid_o in reset");
    rst_n = 1'b1;

    run_fetches(PHASE1_N, 1'b1);

    // flush with cache on, counters back to zero
    csr_write(ADDR_W'(CTRL), 32'h3);
    reset_model(1'b1);
    check_counters();
    restart(RESET_PC);
    run_fetches(PHASE2_N, 1'b0);
    check_counters();  // first touch of each line after flush is a miss

    // cache off plus flush, every fetch goes to the bus
    csr_write(ADDR_W'(CTRL), 32'h2);
    reset_model(1'b0);
    csr_read(ADDR_W'(CTRL), rd_data);
    check_count(rd_data, '0, "CTRL enable");
    csr_read(32'hC, rd_data);
    check_count(rd_data, '0, "unmapped register");
    check_counters();
    restart(RESET_PC);
    run_fetches(PHASE3_N, 1'b0);
    check_counters();  // hits stay 0

    $display("errors: %0d instruction, %0d counter, %0d signal", inst_errs, cnt_errs, sig_errs);
    if (inst_errs + cnt_errs + sig_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: files.f
if_pkg.sv
pc_gen.sv
icache.sv
axi_rd_master.sv
fetch_csr.sv
if_stage.sv
tb_axi_mem.sv
tb_if_stage.sv

// File: run.sh
#!/bin/sh
# verilator build and run of the fetch stage testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_if_stage -f files.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_if_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1
